//--- rtl/branch_cfg.svh
`ifndef BRANCH_CFG_SVH
`define BRANCH_CFG_SVH

// branch op codes, anything else is treated as a non-branch op
`define ALU_BEQ  8'h58
`define ALU_BNE  8'h59
`define ALU_BLT  8'h5a
`define ALU_BGE  8'h5b
`define ALU_BLTU 8'h5c
`define ALU_BGEU 8'h5d
`define ALU_B    8'h5e
`define ALU_BL   8'h5f
`define ALU_JIRL 8'h60

// history table index width, 16 entries
`define BHT_INDEX_BITS 4

// perf counter width
`define PERF_CNT_BITS 16

`endif

//--- rtl/branch_pkg.sv
`default_nettype none

`include "branch_cfg.svh"

package branch_pkg;

    // address and data words
    typedef logic [31:0] bus32_t;

    typedef logic [7:0] alu_op_t;

    // predictor table
    typedef logic [`BHT_INDEX_BITS-1:0] bht_idx_t;
    typedef logic [1:0]                 bht_ctr_t;

    typedef logic [`PERF_CNT_BITS-1:0] perf_cnt_t;

    // one operation in flight, stepped through these states
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_LOOKUP,
        SEQ_RESOLVE,
        SEQ_OUT
    } seq_state_t;

endpackage

`default_nettype wire

//--- rtl/branch_alu.sv
`timescale 1ns/100ps
`default_nettype none

`include "branch_cfg.svh"

module branch_alu
    import branch_pkg::*;
(
    input  bus32_t  pc,
    input  bus32_t  inst,
    input  alu_op_t aluop,
    input  bus32_t  reg1,
    input  bus32_t  reg2,
    input  logic    pre_is_branch_taken,
    input  bus32_t  pre_branch_addr,
    output logic    update_en,
    output logic    taken_actual,
    output logic    branch_flush,
    output bus32_t  actual_addr,
    output bus32_t  branch_target,
    output bus32_t  link_res
);

    logic   is_signed;
    logic   ops_equal;
    logic   ops_less;
    bus32_t offs16;
    bus32_t offs26;
    bus32_t pc_plus4;
    logic   is_branch;
    logic   is_taken;
    bus32_t target_addr;

    assign is_signed = (aluop == `ALU_BLT) || (aluop == `ALU_BGE);
    assign ops_equal = (reg1 == reg2);

    // BLT/BGE compare signed, BLTU/BGEU unsigned
    assign ops_less = is_signed ? ($signed(reg1) < $signed(reg2)) : (reg1 < reg2);

    // sign extended word offsets from the instruction immediates
    assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    assign pc_plus4 = pc + 32'd4;

    // condition and target per op
    always_comb begin
        is_branch   = 1'b1;
        is_taken    = 1'b0;
        target_addr = '0;
        link_res    = '0;
        case (aluop)
            `ALU_BEQ: begin
                is_taken = ops_equal;
            end
            `ALU_BNE: begin
                is_taken = !ops_equal;
            end
            `ALU_BLT, `ALU_BLTU: begin
                is_taken = ops_less;
            end
            `ALU_BGE, `ALU_BGEU: begin
                is_taken = !ops_less;
            end
            `ALU_B: begin
                is_taken = 1'b1;
            end
            `ALU_BL: begin
                is_taken = 1'b1;
                link_res = pc_plus4;
            end
            `ALU_JIRL: begin
                is_taken = 1'b1;
                link_res = pc_plus4;
            end
            default: begin
                is_branch = 1'b0;
            end
        endcase

        if (is_taken) begin
            case (aluop)
                `ALU_B, `ALU_BL: begin
                    target_addr = pc + offs26;
                end
                `ALU_JIRL: begin
                    target_addr = reg1 + offs16;
                end
                default: begin
                    target_addr = pc + offs16;
                end
            endcase
        end
    end

    // compare the outcome against the prediction
    always_comb begin
        update_en    = is_branch;
        taken_actual = is_branch && is_taken;
        branch_flush = 1'b0;
        actual_addr  = '0;
        if (is_branch) begin
            if (is_taken) begin
                actual_addr = target_addr;
                if (!pre_is_branch_taken) begin
                    branch_flush = 1'b1;
                end else if (pre_branch_addr != target_addr) begin
                    // right direction, wrong target
                    branch_flush = 1'b1;
                end
            end else if (pre_is_branch_taken) begin
                branch_flush = 1'b1;
                actual_addr  = pc_plus4;
            end
        end
    end

    assign branch_target = target_addr;

endmodule

`default_nettype wire

//--- rtl/branch_predictor.sv
`timescale 1ns/100ps
`default_nettype none

`include "branch_cfg.svh"

module branch_predictor
    import branch_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   lookup_en,
    input  bus32_t lookup_pc,
    input  logic   update_en,
    input  bus32_t update_pc,
    input  logic   update_taken,
    input  bus32_t update_target,
    output logic   pred_taken,
    output bus32_t pred_addr
);

    localparam int BHT_DEPTH = 1 << `BHT_INDEX_BITS;

    bht_ctr_t ctr_mem    [BHT_DEPTH];
    bus32_t   target_mem [BHT_DEPTH];

    bht_idx_t rd_idx_q;
    bht_idx_t wr_idx;
    bht_ctr_t rd_ctr;
    bht_ctr_t wr_ctr;

    // no tags, pcs with equal low bits share an entry
    assign wr_idx = update_pc[`BHT_INDEX_BITS+1:2];

    // read index is sampled with the operation, table read follows next cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_idx_q <= '0;
        end else if (lookup_en) begin
            rd_idx_q <= lookup_pc[`BHT_INDEX_BITS+1:2];
        end
    end

    assign rd_ctr     = ctr_mem[rd_idx_q];
    assign pred_taken = rd_ctr[1];
    assign pred_addr  = pred_taken ? target_mem[rd_idx_q] : '0;

    // saturating 2-bit counter step
    always_comb begin
        wr_ctr = ctr_mem[wr_idx];
        if (update_taken) begin
            if (wr_ctr != 2'b11) begin
                wr_ctr = wr_ctr + 2'd1;
            end
        end else if (wr_ctr != 2'b00) begin
            wr_ctr = wr_ctr - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // weakly not taken everywhere
            for (int i = 0; i < BHT_DEPTH; i++) begin
                ctr_mem[i]    <= 2'b01;
                target_mem[i] <= '0;
            end
        end else if (update_en) begin
            ctr_mem[wr_idx] <= wr_ctr;
            if (update_taken) begin
                target_mem[wr_idx] <= update_target;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/branch_stage_regs.sv
`timescale 1ns/100ps
`default_nettype none

module branch_stage_regs
    import branch_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    capture_en,
    input  logic    resolve_en,
    input  bus32_t  pc,
    input  bus32_t  inst,
    input  alu_op_t aluop,
    input  bus32_t  reg1,
    input  bus32_t  reg2,
    input  logic    pred_taken,
    input  bus32_t  pred_addr,
    input  logic    update_en,
    input  logic    taken_actual,
    input  logic    branch_flush,
    input  bus32_t  actual_addr,
    input  bus32_t  link_res,
    output bus32_t  pc_q,
    output bus32_t  inst_q,
    output alu_op_t aluop_q,
    output bus32_t  reg1_q,
    output bus32_t  reg2_q,
    output logic    pre_taken_q,
    output bus32_t  pre_addr_q,
    output logic    is_branch_q,
    output logic    taken_actual_q,
    output logic    branch_flush_q,
    output bus32_t  actual_addr_q,
    output bus32_t  link_res_q
);

    // marks the lookup cycle, prediction is valid then
    logic pred_load;

    always_ff @(posedge clk) begin
        if (reset) begin
            pred_load <= 1'b0;
        end else begin
            pred_load <= capture_en;
        end
    end

    always_ff @(posedge clk) begin
        if (capture_en) begin
            pc_q    <= pc;
            inst_q  <= inst;
            aluop_q <= aluop;
            reg1_q  <= reg1;
            reg2_q  <= reg2;
        end
        if (pred_load) begin
            pre_taken_q <= pred_taken;
            pre_addr_q  <= pred_addr;
        end
        // result held for the output stream
        if (resolve_en) begin
            is_branch_q    <= update_en;
            taken_actual_q <= taken_actual;
            branch_flush_q <= branch_flush;
            actual_addr_q  <= actual_addr;
            link_res_q     <= link_res;
        end
    end

endmodule

`default_nettype wire

//--- rtl/branch_seq_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module branch_seq_fsm
    import branch_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic in_valid,
    input  logic out_ready,
    output logic in_ready,
    output logic capture_en,
    output logic lookup_en,
    output logic resolve_en,
    output logic out_valid
);

    seq_state_t state_q;
    seq_state_t state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            SEQ_IDLE: begin
                if (in_valid) begin
                    state_d = SEQ_LOOKUP;
                end
            end
            SEQ_LOOKUP:  state_d = SEQ_RESOLVE;
            SEQ_RESOLVE: state_d = SEQ_OUT;
            SEQ_OUT: begin
                // hold the result until the sink takes it
                if (out_ready) begin
                    state_d = SEQ_IDLE;
                end
            end
            default: state_d = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= SEQ_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign in_ready   = (state_q == SEQ_IDLE);
    assign capture_en = in_valid && in_ready;
    assign lookup_en  = capture_en;
    assign resolve_en = (state_q == SEQ_RESOLVE);
    assign out_valid  = (state_q == SEQ_OUT);

endmodule

`default_nettype wire

//--- rtl/branch_perf_counters.sv
`timescale 1ns/100ps
`default_nettype none

module branch_perf_counters
    import branch_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      resolve_en,
    input  logic      update_en,
    input  logic      branch_flush,
    output perf_cnt_t branch_count,
    output perf_cnt_t mispredict_count
);

    logic count_branch;
    logic count_miss;

    // sticks at all ones
    function automatic perf_cnt_t sat_inc(input perf_cnt_t value);
        sat_inc = (value == '1) ? value : value + 1'b1;
    endfunction

    assign count_branch = resolve_en && update_en;
    assign count_miss   = count_branch && branch_flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            branch_count     <= '0;
            mispredict_count <= '0;
        end else begin
            if (count_branch) begin
                branch_count <= sat_inc(branch_count);
            end
            if (count_miss) begin
                mispredict_count <= sat_inc(mispredict_count);
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/branch_unit_top.sv
`timescale 1ns/100ps
`default_nettype none

module branch_unit_top
    import branch_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    output logic      in_ready,
    input  bus32_t    pc,
    input  bus32_t    inst,
    input  alu_op_t   aluop,
    input  bus32_t    reg1,
    input  bus32_t    reg2,
    output logic      out_valid,
    input  logic      out_ready,
    output logic      branch_flush,
    output logic      taken_actual,
    output bus32_t    actual_addr,
    output bus32_t    link_res,
    output logic      is_branch,
    output perf_cnt_t branch_count,
    output perf_cnt_t mispredict_count
);

    logic    capture_en;
    logic    lookup_en;
    logic    resolve_en;
    bus32_t  pc_q;
    bus32_t  inst_q;
    alu_op_t aluop_q;
    bus32_t  reg1_q;
    bus32_t  reg2_q;
    logic    pre_taken_q;
    bus32_t  pre_addr_q;
    logic    pred_taken;
    bus32_t  pred_addr;
    logic    alu_update_en;
    logic    alu_taken;
    logic    alu_flush;
    bus32_t  alu_actual_addr;
    bus32_t  alu_target;
    bus32_t  alu_link_res;
    logic    bht_update_en;

    // table write only in the resolve cycle
    assign bht_update_en = resolve_en && alu_update_en;

    branch_seq_fsm seq_i (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .out_ready  (out_ready),
        .in_ready   (in_ready),
        .capture_en (capture_en),
        .lookup_en  (lookup_en),
        .resolve_en (resolve_en),
        .out_valid  (out_valid)
    );

    branch_stage_regs regs_i (
        .clk            (clk),
        .reset          (reset),
        .capture_en     (capture_en),
        .resolve_en     (resolve_en),
        .pc             (pc),
        .inst           (inst),
        .aluop          (aluop),
        .reg1           (reg1),
        .reg2           (reg2),
        .pred_taken     (pred_taken),
        .pred_addr      (pred_addr),
        .update_en      (alu_update_en),
        .taken_actual   (alu_taken),
        .branch_flush   (alu_flush),
        .actual_addr    (alu_actual_addr),
        .link_res       (alu_link_res),
        .pc_q           (pc_q),
        .inst_q         (inst_q),
        .aluop_q        (aluop_q),
        .reg1_q         (reg1_q),
        .reg2_q         (reg2_q),
        .pre_taken_q    (pre_taken_q),
        .pre_addr_q     (pre_addr_q),
        .is_branch_q    (is_branch),
        .taken_actual_q (taken_actual),
        .branch_flush_q (branch_flush),
        .actual_addr_q  (actual_addr),
        .link_res_q     (link_res)
    );

    branch_predictor bht_i (
        .clk           (clk),
        .reset         (reset),
        .lookup_en     (lookup_en),
        .lookup_pc     (pc),
        .update_en     (bht_update_en),
        .update_pc     (pc_q),
        .update_taken  (alu_taken),
        .update_target (alu_target),
        .pred_taken    (pred_taken),
        .pred_addr     (pred_addr)
    );

    branch_alu alu_i (
        .pc                  (pc_q),
        .inst                (inst_q),
        .aluop               (aluop_q),
        .reg1                (reg1_q),
        .reg2                (reg2_q),
        .pre_is_branch_taken (pre_taken_q),
        .pre_branch_addr     (pre_addr_q),
        .update_en           (alu_update_en),
        .taken_actual        (alu_taken),
        .branch_flush        (alu_flush),
        .actual_addr         (alu_actual_addr),
        .branch_target       (alu_target),
        .link_res            (alu_link_res)
    );

    branch_perf_counters perf_i (
        .clk              (clk),
        .reset            (reset),
        .resolve_en       (resolve_en),
        .update_en        (alu_update_en),
        .branch_flush     (alu_flush),
        .branch_count     (branch_count),
        .mispredict_count (mispredict_count)
    );

endmodule

`default_nettype wire

//--- tb/branch_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "branch_cfg.svh"

module branch_unit_tb
    import branch_pkg::*;
();

    localparam int        CLK_PERIOD     = 100;
    localparam int        RESET_CYCLES   = 16;
    localparam int        CYCLES_PER_ROW = 40;
    localparam int        BHT_DEPTH      = 1 << `BHT_INDEX_BITS;
    localparam bit [31:0] SEED           = 32'hca11_9b76;
    localparam alu_op_t   OP_NONBRANCH   = 8'h10;

    logic      clk;
    logic      reset;
    logic      in_valid;
    logic      in_ready;
    bus32_t    pc;
    bus32_t    inst;
    alu_op_t   aluop;
    bus32_t    reg1;
    bus32_t    reg2;
    logic      out_valid;
    logic      out_ready;
    logic      branch_flush;
    logic      taken_actual;
    bus32_t    actual_addr;
    bus32_t    link_res;
    logic      is_branch;
    perf_cnt_t branch_count;
    perf_cnt_t mispredict_count;

    // stimulus table, one entry per operation, with the expected direction
    bus32_t  row_pc[$];
    bus32_t  row_inst[$];
    alu_op_t row_op[$];
    bus32_t  row_reg1[$];
    bus32_t  row_reg2[$];
    logic    row_taken[$];
    logic    rows_loaded;

    // reference copy of the history table
    bht_ctr_t  m_ctr[BHT_DEPTH];
    bus32_t    m_tgt[BHT_DEPTH];
    logic      exp_flush;
    logic      exp_taken;
    logic      exp_branch;
    bus32_t    exp_addr;
    bus32_t    exp_link;
    perf_cnt_t exp_branches;
    perf_cnt_t exp_misses;
    int        val_errs;
    int        proto_errs;

    branch_unit_top dut_i (
        .clk              (clk),
        .reset            (reset),
        .in_valid         (in_valid),
        .in_ready         (in_ready),
        .pc               (pc),
        .inst             (inst),
        .aluop            (aluop),
        .reg1             (reg1),
        .reg2             (reg2),
        .out_valid        (out_valid),
        .out_ready        (out_ready),
        .branch_flush     (branch_flush),
        .taken_actual     (taken_actual),
        .actual_addr      (actual_addr),
        .link_res         (link_res),
        .is_branch        (is_branch),
        .branch_count     (branch_count),
        .mispredict_count (mispredict_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        wait (rows_loaded);
        #((row_pc.size() * CYCLES_PER_ROW + RESET_CYCLES) * CLK_PERIOD);
        $display("run timed out, the DUT never completed its handshakes");
        $display("** FAIL **");
        $finish;
    end

    // immediate fields in word units
    function automatic bus32_t enc_off16(input int words);
        bus32_t w;
        w = '0;
        w[25:10] = words[15:0];
        return w;
    endfunction

    function automatic bus32_t enc_off26(input int words);
        bus32_t w;
        w = '0;
        w[25:10] = words[15:0];
        w[9:0]   = words[25:16];
        return w;
    endfunction

    function automatic logic is_branch_op(input alu_op_t op);
        logic br;
        case (op)
            `ALU_BEQ, `ALU_BNE, `ALU_BLT, `ALU_BGE, `ALU_BLTU, `ALU_BGEU: br = 1'b1;
            `ALU_B, `ALU_BL, `ALU_JIRL: br = 1'b1;
            default: br = 1'b0;
        endcase
        return br;
    endfunction

    function automatic bus32_t branch_dest(input int i);
        logic [25:0] raw26;
        int          offs;
        bus32_t      dest;
        case (row_op[i])
            `ALU_B, `ALU_BL: begin
                raw26 = {row_inst[i][9:0], row_inst[i][25:10]};
                offs  = $signed(raw26);
                dest  = row_pc[i] + offs * 4;
            end
            `ALU_JIRL: begin
                offs = $signed(row_inst[i][25:10]);
                dest = row_reg1[i] + offs * 4;
            end
            default: begin
                offs = $signed(row_inst[i][25:10]);
                dest = row_pc[i] + offs * 4;
            end
        endcase
        return dest;
    endfunction

    task automatic add_row(input bus32_t p, input bus32_t ins, input alu_op_t op,
                           input bus32_t r1, input bus32_t r2, input logic tk);
        row_pc.push_back(p);
        row_inst.push_back(ins);
        row_op.push_back(op);
        row_reg1.push_back(r1);
        row_reg2.push_back(r2);
        row_taken.push_back(tk);
    endtask

    task automatic load_table();
        // compares on fresh pcs, operands differ only in signedness
        add_row(32'h1000, enc_off16(8), `ALU_BEQ, 32'hffff_fff0, 32'h10, 1'b0);
        add_row(32'h1004, enc_off16(8), `ALU_BNE, 32'hffff_fff0, 32'h10, 1'b1);
        add_row(32'h1008, enc_off16(-4), `ALU_BLT, 32'hffff_fff0, 32'h10, 1'b1);
        add_row(32'h100c, enc_off16(12), `ALU_BGE, 32'hffff_fff0, 32'h10, 1'b0);
        add_row(32'h1010, enc_off16(12), `ALU_BLTU, 32'hffff_fff0, 32'h10, 1'b0);
        add_row(32'h1014, enc_off16(-20), `ALU_BGEU, 32'hffff_fff0, 32'h10, 1'b1);
        add_row(32'h1018, enc_off16(6), `ALU_BEQ, 32'h1234_5678, 32'h1234_5678, 1'b1);
        // unconditional jumps
        add_row(32'h101c, enc_off26(32'h12345), `ALU_B, 32'h0, 32'h0, 1'b1);
        add_row(32'h1020, enc_off26(-64), `ALU_BL, 32'h0, 32'h0, 1'b1);
        add_row(32'h1024, enc_off16(16), `ALU_JIRL, 32'h8000_0000, 32'h0, 1'b1);
        // training one entry, then not taken, then a new target
        add_row(32'h1028, enc_off16(32), `ALU_BNE, 32'h1, 32'h2, 1'b1);
        add_row(32'h1028, enc_off16(32), `ALU_BNE, 32'h1, 32'h2, 1'b1);
        add_row(32'h1028, enc_off16(32), `ALU_BNE, 32'h1, 32'h2, 1'b1);
        add_row(32'h1028, enc_off16(32), `ALU_BNE, 32'h7, 32'h7, 1'b0);
        add_row(32'h1028, enc_off16(64), `ALU_BNE, 32'h1, 32'h2, 1'b1);
        add_row(32'h102c, 32'h0, OP_NONBRANCH, 32'h5, 32'h5, 1'b0);
        // aliases with 0x1028
        add_row(32'h1068, enc_off16(-8), `ALU_BEQ, 32'h3, 32'h3, 1'b1);
        add_row(32'h1018, enc_off16(6), `ALU_BEQ, 32'h1234_5678, 32'h1234_5678, 1'b1);
        add_row(32'h1024, enc_off16(16), `ALU_JIRL, 32'h8000_0000, 32'h0, 1'b1);
    endtask

    task automatic model_row(input int i);
        bht_idx_t idx;
        logic     br;
        logic     p_taken;
        bus32_t   p_addr;
        bus32_t   dest;
        idx     = row_pc[i][`BHT_INDEX_BITS+1:2];
        br      = is_branch_op(row_op[i]);
        p_taken = (m_ctr[idx] >= 2'd2);
        p_addr  = p_taken ? m_tgt[idx] : '0;
        dest    = branch_dest(i);
        exp_branch = br;
        exp_taken  = br && row_taken[i];
        exp_flush  = 1'b0;
        exp_addr   = '0;
        exp_link   = '0;
        if (row_op[i] == `ALU_BL || row_op[i] == `ALU_JIRL) begin
            exp_link = row_pc[i] + 32'd4;
        end
        if (exp_taken) begin
            exp_addr  = dest;
            exp_flush = !p_taken || (p_addr != dest);
        end else if (br && p_taken) begin
            exp_addr  = row_pc[i] + 32'd4;
            exp_flush = 1'b1;
        end
        if (br) begin
            if (row_taken[i]) begin
                if (m_ctr[idx] != 2'd3) begin
                    m_ctr[idx] = m_ctr[idx] + 2'd1;
                end
                m_tgt[idx] = dest;
            end else if (m_ctr[idx] != 2'd0) begin
                m_ctr[idx] = m_ctr[idx] - 2'd1;
            end
            exp_branches = exp_branches + 1'b1;
            if (exp_flush) begin
                exp_misses = exp_misses + 1'b1;
            end
        end
    endtask

    task automatic check_bus(input string name, input bus32_t exp, input bus32_t act);
        if (act !== exp) begin
            val_errs++;
            $display("ERR %s expected %08h got %08h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            val_errs++;
            $display("ERR %s expected %0h got %0h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input perf_cnt_t exp, input perf_cnt_t act);
        if (act !== exp) begin
            val_errs++;
            $display("ERR %s expected %04h got %04h", name, exp, act);
        end
    endtask

    task automatic check_outputs();
        check_bit("branch_flush", exp_flush, branch_flush);
        check_bit("taken_actual", exp_taken, taken_actual);
        check_bit("is_branch", exp_branch, is_branch);
        check_bus("actual_addr", exp_addr, actual_addr);
        check_bus("link_res", exp_link, link_res);
        check_count("branch_count", exp_branches, branch_count);
        check_count("mispredict_count", exp_misses, mispredict_count);
    endtask

    task automatic send_row(input int i);
        @(posedge clk);
        in_valid <= 1'b1;
        pc       <= row_pc[i];
        inst     <= row_inst[i];
        aluop    <= row_op[i];
        reg1     <= row_reg1[i];
        reg2     <= row_reg2[i];
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        // transfer on this edge
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_result(input int i);
        int lat;
        lat = 0;
        @(negedge clk);
        while (!out_valid) begin
            lat++;
            @(negedge clk);
        end
        if (lat != 2) begin
            proto_errs++;
            $display("row %0d: result came %0d cycles after the input transfer, not 2", i, lat);
        end
    endtask

    initial begin
        int seed_val;
        int hold;
        rows_loaded  = 1'b0;
        reset        = 1'b1;
        in_valid     = 1'b0;
        pc           = '0;
        inst         = '0;
        aluop        = '0;
        reg1         = '0;
        reg2         = '0;
        out_ready    = 1'b0;
        val_errs     = 0;
        proto_errs   = 0;
        exp_branches = '0;
        exp_misses   = '0;
        seed_val     = $urandom(SEED);
        for (int k = 0; k < BHT_DEPTH; k++) begin
            m_ctr[k] = 2'b01;
            m_tgt[k] = '0;
        end
        load_table();
        rows_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_bit("in_ready", 1'b1, in_ready);
        check_bit("out_valid", 1'b0, out_valid);
        check_count("branch_count", '0, branch_count);
        check_count("mispredict_count", '0, mispredict_count);

        for (int i = 0; i < row_pc.size(); i++) begin
            model_row(i);
            send_row(i);
            wait_result(i);
            check_outputs();
            // random back-pressure, result must hold
            hold = $urandom % 6;
            repeat (hold) begin
                @(negedge clk);
                check_outputs();
                check_bit("out_valid", 1'b1, out_valid);
                check_bit("in_ready", 1'b0, in_ready);
            end
            @(posedge clk);
            out_ready <= 1'b1;
            @(posedge clk);
            out_ready <= 1'b0;
        end

        @(negedge clk);
        check_bit("in_ready", 1'b1, in_ready);
        check_count("branch_count", exp_branches, branch_count);
        check_count("mispredict_count", exp_misses, mispredict_count);
        $display("errors: %0d value, %0d protocol", val_errs, proto_errs);
        if (val_errs == 0 && proto_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+rtl
rtl/branch_pkg.sv
rtl/branch_alu.sv
rtl/branch_predictor.sv
rtl/branch_stage_regs.sv
rtl/branch_seq_fsm.sv
rtl/branch_perf_counters.sv
rtl/branch_unit_top.sv
tb/branch_unit_tb.sv

//--- Bender.yml
package:
  name: branch_unit

export_include_dirs:
  - rtl

sources:
  - rtl/branch_pkg.sv
  - rtl/branch_alu.sv
  - rtl/branch_predictor.sv
  - rtl/branch_stage_regs.sv
  - rtl/branch_seq_fsm.sv
  - rtl/branch_perf_counters.sv
  - rtl/branch_unit_top.sv
  - target: test
    files:
      - tb/branch_unit_tb.sv
